//--- rnn_config.svh
`ifndef RNN_CONFIG_SVH
`define RNN_CONFIG_SVH

// Q8.8 data path
`define RNN_DATA_W 16
`define RNN_FRAC 8

// Headroom for one neuron sum of RNN_HIDDEN+1 terms
`define RNN_ACC_W 24

`define RNN_HIDDEN 4

// Queue slots, one input credit per slot
`define RNN_IN_DEPTH 4

`define RNN_OUT_CREDITS 2

`endif

//--- rnn_types_pkg.sv
`include "rnn_config.svh"

package rnn_types_pkg;

    typedef logic signed [`RNN_DATA_W-1:0] data_t;
    typedef logic signed [`RNN_ACC_W-1:0] acc_t;
    typedef logic signed [`RNN_DATA_W-1:0] coef_t;
    typedef logic [$clog2(`RNN_HIDDEN)-1:0] idx_t;

    typedef data_t [`RNN_HIDDEN-1:0] hidden_vec_t;

    typedef struct packed {
        data_t x;
        logic  clear;
    } step_cmd_t;

    typedef struct packed {
        data_t       y;
        hidden_vec_t h;
    } rnn_result_t;

    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_HIDDEN,
        EXEC_OUTPUT,
        EXEC_DONE
    } exec_state_t;

    localparam data_t DATA_MAX = 16'sh7FFF;
    localparam data_t DATA_MIN = 16'sh8000;

    // Floor of the Q8.8 product, kept at accumulator width
    function automatic acc_t fx_product(input data_t d, input coef_t c);
        logic signed [2*`RNN_DATA_W-1:0] p;
        p = d * c;
        return acc_t'(p >>> `RNN_FRAC);
    endfunction

    function automatic data_t fx_saturate(input acc_t a);
        if (a > acc_t'(DATA_MAX)) begin
            return DATA_MAX;
        end else if (a < acc_t'(DATA_MIN)) begin
            return DATA_MIN;
        end
        return data_t'(a);
    endfunction

endpackage

//--- rnn_weights_pkg.sv
`include "rnn_config.svh"

package rnn_weights_pkg;

    import rnn_types_pkg::*;

    // Input to hidden, one per neuron
    // 1.75, -1.5, 0.75, 1.25
    localparam coef_t W_I2H [`RNN_HIDDEN] = '{
        16'sh01C0,
        -16'sh0180,
        16'sh00C0,
        16'sh0140
    };

    // Hidden to hidden, [i][j] feeds old h[i] into neuron j
    // Kept small so the state decays between large inputs
    localparam coef_t W_H2H [`RNN_HIDDEN][`RNN_HIDDEN] = '{
        '{  16'sh0040, -16'sh0020,  16'sh0060,  16'sh0010 },
        '{ -16'sh0030,  16'sh0040,  16'sh0020, -16'sh0050 },
        '{  16'sh0020,  16'sh0050, -16'sh0040,  16'sh0030 },
        '{ -16'sh0010,  16'sh0020,  16'sh0030, -16'sh0040 }
    };

    // Hidden to output
    // 1.5, -1.25, 1.75, -0.5
    localparam coef_t W_H2O [`RNN_HIDDEN] = '{
        16'sh0180,
        -16'sh0140,
        16'sh01C0,
        -16'sh0080
    };

endpackage

//--- rnn_decode.sv
`timescale 1ns/1ns
`include "rnn_config.svh"

module rnn_decode (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_sample_valid,
    input  rnn_types_pkg::step_cmd_t i_sample,
    output logic                     o_sample_credit,
    input  logic                     i_ready,
    output logic                     o_start,
    output rnn_types_pkg::step_cmd_t o_step
);

    import rnn_types_pkg::*;

    localparam int PTR_W = $clog2(`RNN_IN_DEPTH);
    localparam int CNT_W = $clog2(`RNN_IN_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`RNN_IN_DEPTH - 1);

    step_cmd_t        queue [`RNN_IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Upstream only sends while it holds a credit, so a push never finds the queue full
    assign push = i_sample_valid;
    assign pop  = o_start && i_ready;

    assign o_start         = (count != '0);
    assign o_step          = queue[rd_ptr];
    assign o_sample_credit = pop;

    always_ff @(posedge i_clk) begin
        if (push) begin
            queue[wr_ptr] <= i_sample;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rnn_execute.sv
`timescale 1ns/1ns
`include "rnn_config.svh"

module rnn_execute (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_start,
    input  rnn_types_pkg::step_cmd_t   i_step,
    output logic                       o_ready,
    output logic                       o_done,
    output rnn_types_pkg::rnn_result_t o_result,
    input  logic                       i_slot_free
);

    import rnn_types_pkg::*;
    import rnn_weights_pkg::*;

    localparam idx_t LAST = idx_t'(`RNN_HIDDEN - 1);

    exec_state_t state;
    hidden_vec_t h_state;
    hidden_vec_t h_new;
    data_t       x_q;
    data_t       y_q;
    acc_t        acc;
    acc_t        h2h_sum;
    acc_t        h2o_sum;
    idx_t        neuron;
    idx_t        term;
    logic        i2h_phase;
    logic        take;

    assign o_ready  = (state == EXEC_IDLE);
    assign take     = i_start && o_ready;
    assign o_done   = (state == EXEC_DONE) && i_slot_free;
    assign o_result = '{y: y_q, h: h_state};

    // Single MAC, the operand pair is picked by the counters
    assign h2h_sum = acc + fx_product(h_state[term], W_H2H[term][neuron]);
    assign h2o_sum = acc + fx_product(h_new[term], W_H2O[term]);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= EXEC_IDLE;
            neuron    <= '0;
            term      <= '0;
            i2h_phase <= 1'b0;
            h_state   <= '0;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (take) begin
                        state     <= EXEC_HIDDEN;
                        neuron    <= '0;
                        term      <= '0;
                        i2h_phase <= 1'b0;
                        if (i_step.clear) begin
                            h_state <= '0;
                        end
                    end
                end
                EXEC_HIDDEN: begin
                    if (i2h_phase) begin
                        i2h_phase <= 1'b0;
                    end else begin
                        term <= (term == LAST) ? '0 : term + 1'b1;
                        if (term == LAST) begin
                            i2h_phase <= 1'b1;
                            neuron    <= (neuron == LAST) ? '0 : neuron + 1'b1;
                            if (neuron == LAST) begin
                                state     <= EXEC_OUTPUT;
                                i2h_phase <= 1'b0;
                            end
                        end
                    end
                end
                EXEC_OUTPUT: begin
                    term <= (term == LAST) ? '0 : term + 1'b1;
                    if (term == LAST) begin
                        state   <= EXEC_DONE;
                        h_state <= h_new;
                    end
                end
                EXEC_DONE: begin
                    if (i_slot_free) begin
                        state <= EXEC_IDLE;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

    // Neuron 0 loads its input term in the transfer cycle itself
    always_ff @(posedge i_clk) begin
        case (state)
            EXEC_IDLE: begin
                if (take) begin
                    x_q <= i_step.x;
                    acc <= fx_product(i_step.x, W_I2H[0]);
                end
            end
            EXEC_HIDDEN: begin
                if (i2h_phase) begin
                    acc <= fx_product(x_q, W_I2H[neuron]);
                end else if (term == LAST) begin
                    h_new[neuron] <= fx_saturate(h2h_sum);
                    // Last neuron hands over a clean accumulator to the output sum
                    acc <= (neuron == LAST) ? '0 : h2h_sum;
                end else begin
                    acc <= h2h_sum;
                end
            end
            EXEC_OUTPUT: begin
                acc <= h2o_sum;
                if (term == LAST) begin
                    y_q <= fx_saturate(h2o_sum);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- rnn_result.sv
`timescale 1ns/1ns
`include "rnn_config.svh"

module rnn_result (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_done,
    input  rnn_types_pkg::rnn_result_t i_result,
    output logic                       o_slot_free,
    output logic                       o_result_valid,
    output rnn_types_pkg::rnn_result_t o_result,
    input  logic                       i_result_credit
);

    import rnn_types_pkg::*;

    localparam int CRED_W = $clog2(`RNN_OUT_CREDITS + 1);

    rnn_result_t       hold;
    logic              full;
    logic [CRED_W-1:0] credits;
    logic              spend;

    assign o_slot_free    = !full;
    assign spend          = full && (credits != '0);
    assign o_result_valid = spend;
    assign o_result       = hold;

    always_ff @(posedge i_clk) begin
        if (i_done) begin
            hold <= i_result;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            full    <= 1'b0;
            credits <= CRED_W'(`RNN_OUT_CREDITS);
        end else begin
            // Execute only raises done while the slot is free
            if (i_done) begin
                full <= 1'b1;
            end else if (spend) begin
                full <= 1'b0;
            end
            case ({spend, i_result_credit})
                2'b10: credits <= credits - CRED_W'(1);
                2'b01: credits <= credits + CRED_W'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- rnn_cell_top.sv
`timescale 1ns/1ns

module rnn_cell_top (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_sample_valid,
    input  rnn_types_pkg::step_cmd_t   i_sample,
    output logic                       o_sample_credit,
    output logic                       o_result_valid,
    output rnn_types_pkg::rnn_result_t o_result,
    input  logic                       i_result_credit
);

    import rnn_types_pkg::*;

    step_cmd_t   step;
    logic        start;
    logic        ready;
    logic        done;
    logic        slot_free;
    rnn_result_t exec_result;

    rnn_decode decode_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_sample_valid  (i_sample_valid),
        .i_sample        (i_sample),
        .o_sample_credit (o_sample_credit),
        .i_ready         (ready),
        .o_start         (start),
        .o_step          (step)
    );

    rnn_execute execute_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (start),
        .i_step      (step),
        .o_ready     (ready),
        .o_done      (done),
        .o_result    (exec_result),
        .i_slot_free (slot_free)
    );

    rnn_result result_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_done          (done),
        .i_result        (exec_result),
        .o_slot_free     (slot_free),
        .o_result_valid  (o_result_valid),
        .o_result        (o_result),
        .i_result_credit (i_result_credit)
    );

endmodule

//--- rnn_cell_properties.sv
`timescale 1ns/1ns
`include "rnn_config.svh"

module rnn_cell_properties (
    input logic i_clk,
    input logic i_rst,
    input logic i_sample_valid,
    input logic i_sample_credit,
    input logic i_result_valid,
    input logic i_result_credit,
    input logic i_start,
    input logic i_ready,
    input logic i_done,
    input logic i_slot_free
);

    localparam int CNT_W       = 8;
    localparam int STEP_CYCLES = `RNN_HIDDEN * (`RNN_HIDDEN + 2);

    // Samples the DUT holds and credits the downstream still owns
    logic [CNT_W-1:0] in_flight;
    logic [CNT_W-1:0] out_credits;

    logic in_fail     = 1'b0;
    logic out_fail    = 1'b0;
    logic step_fail   = 1'b0;
    logic handoff_fail = 1'b0;
    logic reset_fail  = 1'b0;
    logic any_fail;

    assign any_fail = in_fail | out_fail | step_fail | handoff_fail | reset_fail;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_flight   <= '0;
            out_credits <= CNT_W'(`RNN_OUT_CREDITS);
        end else begin
            in_flight   <= in_flight + CNT_W'(i_sample_valid) - CNT_W'(i_sample_credit);
            out_credits <= out_credits - CNT_W'(i_result_valid) + CNT_W'(i_result_credit);
        end
    end

    // A step is offered exactly while a sample sits in the queue
    assert property (@(posedge i_clk) disable iff (i_rst)
        (in_flight <= CNT_W'(`RNN_IN_DEPTH)) && (!i_sample_credit || in_flight != '0)
        && (i_start == (in_flight != '0)))
        else begin
            in_fail = 1'b1;
            $error("Input credit or step start out of step with queued samples");
        end

    assert property (@(posedge i_clk) disable iff (i_rst)
        i_result_valid |-> out_credits != '0)
        else begin
            out_fail = 1'b1;
            $error("o_result_valid without a downstream credit");
        end

    // Fixed engine latency from transfer to the done state
    assert property (@(posedge i_clk) disable iff (i_rst)
        (i_start && i_ready) |-> ##(STEP_CYCLES - 1) (!i_ready && !i_done)
                                 ##1 (!i_ready && (i_done || !i_slot_free)))
        else begin
            step_fail = 1'b1;
            $error("Engine step did not take %0d cycles", STEP_CYCLES);
        end

    // Handoff fills the holding register and frees the engine
    assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> (i_ready && !i_slot_free))
        else begin
            handoff_fail = 1'b1;
            $error("Result handoff did not fill the slot and idle the engine");
        end

    assert property (@(posedge i_clk)
        i_rst |=> (!i_result_valid && !i_sample_credit && !i_start && !i_done))
        else begin
            reset_fail = 1'b1;
            $error("Outputs active during or right after reset");
        end

endmodule

bind rnn_cell_top rnn_cell_properties props_inst (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_sample_valid  (i_sample_valid),
    .i_sample_credit (o_sample_credit),
    .i_result_valid  (o_result_valid),
    .i_result_credit (i_result_credit),
    .i_start         (start),
    .i_ready         (ready),
    .i_done          (done),
    .i_slot_free     (slot_free)
);

//--- tb_rnn_cell.sv
`timescale 1ns/1ns
`include "rnn_config.svh"

module tb_rnn_cell;

    import rnn_types_pkg::*;
    import rnn_weights_pkg::*;

    localparam int NUM_SAMPLES    = 40;
    localparam int STALL_CYCLES   = 150;
    localparam int TIMEOUT_CYCLES = 8 + NUM_SAMPLES * (24 + 6) + 400;

    logic        i_clk;
    logic        i_rst;
    logic        i_sample_valid;
    step_cmd_t   i_sample;
    logic        o_sample_credit;
    logic        o_result_valid;
    rnn_result_t o_result;
    logic        i_result_credit;

    step_cmd_t   samples [NUM_SAMPLES];
    rnn_result_t exp_q [$];
    hidden_vec_t model_h;
    logic        withhold;
    int          samples_sent;
    int          credits_back;
    int          results_seen;
    int          credits_given;
    int          sat_seen;
    int          cycle_count;

    rnn_cell_top i_dut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_sample_valid  (i_sample_valid),
        .i_sample        (i_sample),
        .o_sample_credit (o_sample_credit),
        .o_result_valid  (o_result_valid),
        .o_result        (o_result),
        .i_result_credit (i_result_credit)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Stopping at first failure");
    endtask

    // Reference step built from the fixed point rules
    task automatic predict_step(input step_cmd_t s, output rnn_result_t r);
        hidden_vec_t h_old;
        hidden_vec_t h_nxt;
        acc_t        sum;
        int          i;
        int          j;
        if (s.clear) begin
            h_old = '0;
        end else begin
            h_old = model_h;
        end
        for (j = 0; j < `RNN_HIDDEN; j++) begin
            sum = fx_product(s.x, W_I2H[j]);
            for (i = 0; i < `RNN_HIDDEN; i++) begin
                sum = sum + fx_product(h_old[i], W_H2H[i][j]);
            end
            h_nxt[j] = fx_saturate(sum);
        end
        sum = '0;
        for (j = 0; j < `RNN_HIDDEN; j++) begin
            sum = sum + fx_product(h_nxt[j], W_H2O[j]);
        end
        r.y = fx_saturate(sum);
        r.h = h_nxt;
        model_h = h_nxt;
    endtask

    function automatic bit is_saturated(input rnn_result_t r);
        bit hit;
        int j;
        hit = (r.y == DATA_MAX) || (r.y == DATA_MIN);
        for (j = 0; j < `RNN_HIDDEN; j++) begin
            if (r.h[j] == DATA_MAX || r.h[j] == DATA_MIN) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic build_samples();
        int v;
        int k;
        for (k = 0; k < NUM_SAMPLES; k++) begin
            if (k < 12 || k >= 30) begin
                v = int'($urandom_range(512)) - 256;
            end else if (k < 20) begin
                // Near full scale with either sign
                v = int'($urandom_range(32'h7FFF, 32'h7000));
                if ($urandom_range(1) == 1) begin
                    v = -v - 1;
                end
            end else begin
                v = int'($urandom_range(384)) - 192;
            end
            samples[k].x     = data_t'(v);
            samples[k].clear = 1'b0;
        end
        // Clear then four steps, then the same five once more
        samples[20].clear = 1'b1;
        for (k = 25; k < 30; k++) begin
            samples[k] = samples[k - 5];
        end
    endtask

    task automatic send_sample(input step_cmd_t s);
        rnn_result_t r;
        while (samples_sent - credits_back >= `RNN_IN_DEPTH) begin
            @(negedge i_clk);
        end
        predict_step(s, r);
        exp_q.push_back(r);
        i_sample_valid = 1'b1;
        i_sample       = s;
        samples_sent++;
        @(negedge i_clk);
        i_sample_valid = 1'b0;
    endtask

    task automatic return_credits();
        forever begin
            @(negedge i_clk);
            if (!withhold && results_seen > credits_given) begin
                i_result_credit = 1'b1;
                credits_given++;
            end else begin
                i_result_credit = 1'b0;
            end
        end
    endtask

    task automatic check_result(input rnn_result_t act);
        rnn_result_t exp_r;
        if (exp_q.size() == 0) begin
            $display("A result arrived while no sample was outstanding");
            abort_run();
        end else begin
            exp_r = exp_q.pop_front();
            results_seen++;
            if (is_saturated(exp_r)) begin
                sat_seen++;
            end
            assert (act.y == exp_r.y) else begin
                $display("ERR o_result.y expected %h actual %h", exp_r.y, act.y);
                abort_run();
            end
            assert (act.h == exp_r.h) else begin
                $display("ERR o_result.h expected %h actual %h", exp_r.h, act.h);
                abort_run();
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_rst && o_result_valid) begin
            check_result(o_result);
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_sample_credit) begin
            credits_back++;
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (i_dut.props_inst.any_fail) begin
            $display("A protocol assertion in rnn_cell_properties failed");
            abort_run();
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycle_count, results_seen, NUM_SAMPLES);
            abort_run();
        end
    end

    initial begin
        int n;
        void'($urandom(32'h198f));
        i_rst           = 1'b1;
        i_sample_valid  = 1'b0;
        i_sample        = '0;
        i_result_credit = 1'b0;
        withhold        = 1'b0;
        model_h         = '0;
        build_samples();
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        fork
            return_credits();
        join_none
        for (n = 0; n < 30; n++) begin
            send_sample(samples[n]);
        end
        // Starve the downstream so the engine and the queue back up
        @(posedge i_clk);
        withhold = 1'b1;
        @(negedge i_clk);
        fork
            begin
                for (n = 30; n < NUM_SAMPLES; n++) begin
                    send_sample(samples[n]);
                end
            end
            begin
                repeat (STALL_CYCLES) @(posedge i_clk);
                withhold = 1'b0;
            end
        join
        wait (results_seen == NUM_SAMPLES);
        repeat (4) @(negedge i_clk);
        if (samples_sent != credits_back) begin
            $display("Input credits not all returned, %0d sent and %0d returned",
                     samples_sent, credits_back);
            abort_run();
        end else if (sat_seen == 0) begin
            $display("No result reached the saturation limits");
            abort_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+.
rnn_types_pkg.sv
rnn_weights_pkg.sv
rnn_decode.sv
rnn_execute.sv
rnn_result.sv
rnn_cell_top.sv
rnn_cell_properties.sv
tb_rnn_cell.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rnn_cell
RTL_TOP   ?= rnn_cell_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
